// File: ins_exec_settings.svh
// Field widths, opcode numbers and condition bits of the execution front end, included by RTL and testbench
`ifndef INS_EXEC_SETTINGS_SVH
`define INS_EXEC_SETTINGS_SVH

// Word and field widths
`define INS_W 16
`define OP_W 6
`define REG_W 5
`define IMM_W 32
`define ALU_W 3

// Field positions inside the instruction word, opcode sits on top
`define SRC_LSB 5
`define DST_LSB 0

// Opcode numbers of the kept subset
`define OP_ADD 6'd0
`define OP_SUB 6'd4
`define OP_AND 6'd9
`define OP_OR 6'd10
`define OP_XOR 6'd11
`define OP_CMP 6'd30
`define OP_MOVEI 6'd38
`define OP_LOAD 6'd41
`define OP_STORE 6'd47
`define OP_JUMP 6'd52
`define OP_JR 6'd53
`define OP_NOP 6'd57

// Condition bits in the destination field of a jump
`define COND_NZ 0
`define COND_Z 1
`define COND_NF 2
`define COND_F 3
`define COND_SEL 4

`endif

// File: ins_exec_pkg.sv
// Shared field types, MOVEI state encoding and the structs passed between the front-end blocks
`default_nettype none

`include "ins_exec_settings.svh"

package ins_exec_pkg;

	// Plain field types
	typedef logic [`INS_W-1:0] ins_word_t;
	typedef logic [`OP_W-1:0] opcode_t;
	typedef logic [`REG_W-1:0] reg_sel_t;
	typedef logic [`IMM_W-1:0] imm_t;
	typedef logic [`ALU_W-1:0] alu_func_t;

	// MOVEI tracking, opcode word then low data then high data
	typedef enum logic [1:0] {
		IDLE,
		AWAIT_LO,
		AWAIT_HI
	} movei_state_t;

	// What an accepted word turned out to be
	// At most one bit high per cycle
	typedef struct packed {
		logic ins;
		logic movei;
		logic imm_lo;
		logic imm_hi;
	} word_take_t;

	// Microcode ROM contents
	typedef struct packed {
		alu_func_t alu_func;
		logic flag_ld;
		logic res_wr;
		logic dst_wr;
		logic mem_rd;
		logic mem_wr;
		logic jump_rel;
		logic jump_abs;
	} microword_t;

	// Same layout once gated with exe and the condition
	typedef struct packed {
		alu_func_t alu_func;
		logic flag_ld;
		logic res_wr;
		logic dst_wr;
		logic mem_rd;
		logic mem_wr;
		logic jump_rel;
		logic jump_abs;
	} exec_strobes_t;

	// ALU flags, held by the datapath through execute
	typedef struct packed {
		logic zero;
		logic carry;
		logic negative;
	} cpu_flags_t;

endpackage

`default_nettype wire

// File: movei_seq.sv
// MOVEI sequencer, sorts every accepted instruction word into instruction, MOVEI or data half
`default_nettype none

`include "ins_exec_settings.svh"

module movei_seq (
	input wire logic sys_clk,
	input wire logic resetl,
	input wire logic go,
	input wire logic ins_rdy,
	input wire ins_exec_pkg::opcode_t opcode,
	output ins_exec_pkg::word_take_t take
);

	ins_exec_pkg::movei_state_t state;
	ins_exec_pkg::movei_state_t state_nxt;
	logic accept;
	logic is_movei;

	// Word only counts while running
	assign accept = ins_rdy & go;

	// Opcode decode, only meaningful in IDLE
	// Data words may carry any bit pattern
	assign is_movei = (opcode == `OP_MOVEI);

	// Classification of the word on the bus
	always_comb begin
		take = '0;
		if (accept) begin
			case (state)
				ins_exec_pkg::IDLE: begin
					take.movei = is_movei;
					take.ins = ~is_movei;
				end
				ins_exec_pkg::AWAIT_LO: take.imm_lo = 1'b1;
				ins_exec_pkg::AWAIT_HI: take.imm_hi = 1'b1;
				default: take = '0;
			endcase
		end
	end

	// Advance only on an accepted word
	always_comb begin
		state_nxt = state;
		if (take.movei)
			state_nxt = ins_exec_pkg::AWAIT_LO;
		if (take.imm_lo)
			state_nxt = ins_exec_pkg::AWAIT_HI;
		if (take.imm_hi)
			state_nxt = ins_exec_pkg::IDLE;
	end

	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			state <= ins_exec_pkg::IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	// Decode registers downstream rely on a single load per word
	a_take_onehot: assert property (@(posedge sys_clk) disable iff (!resetl)
		$onehot0(take))
		else $error("movei_seq: more than one take bit");

	// Unused encoding would lock out every further instruction
	a_state_legal: assert property (@(posedge sys_clk) disable iff (!resetl)
		state inside {ins_exec_pkg::IDLE, ins_exec_pkg::AWAIT_LO, ins_exec_pkg::AWAIT_HI})
		else $error("movei_seq: illegal state");

endmodule

`default_nettype wire

// File: ins_regs.sv
// Decode stage, holds operand fields, looks up the microword and builds the MOVEI immediate
`default_nettype none

`include "ins_exec_settings.svh"

module ins_regs (
	input wire logic sys_clk,
	input wire logic resetl,
	input wire ins_exec_pkg::word_take_t take,
	input wire ins_exec_pkg::ins_word_t ins_word,
	output logic exe,
	output ins_exec_pkg::microword_t mword,
	output ins_exec_pkg::reg_sel_t src_reg,
	output ins_exec_pkg::reg_sel_t dst_reg,
	output ins_exec_pkg::imm_t imm_data,
	output logic imm_wr,
	output ins_exec_pkg::reg_sel_t imm_dst
);

	ins_exec_pkg::opcode_t opc;
	ins_exec_pkg::reg_sel_t src_fld;
	ins_exec_pkg::reg_sel_t dst_fld;
	ins_exec_pkg::microword_t rom_word;
	ins_exec_pkg::ins_word_t imm_lo;
	ins_exec_pkg::reg_sel_t movei_dst;

	// Field split of the incoming word
	assign opc = ins_word[`INS_W-1 -: `OP_W];
	assign src_fld = ins_word[`SRC_LSB +: `REG_W];
	assign dst_fld = ins_word[`DST_LSB +: `REG_W];

	// Microcode ROM
	// Anything not listed decodes as NOP
	always_comb begin
		rom_word = '0;
		case (opc)
			`OP_ADD: begin
				rom_word.alu_func = 3'b000;
				rom_word.flag_ld = 1'b1;
				rom_word.res_wr = 1'b1;
				rom_word.dst_wr = 1'b1;
			end
			`OP_SUB: begin
				rom_word.alu_func = 3'b001;
				rom_word.flag_ld = 1'b1;
				rom_word.res_wr = 1'b1;
				rom_word.dst_wr = 1'b1;
			end
			`OP_AND: begin
				rom_word.alu_func = 3'b100;
				rom_word.flag_ld = 1'b1;
				rom_word.res_wr = 1'b1;
				rom_word.dst_wr = 1'b1;
			end
			`OP_OR: begin
				rom_word.alu_func = 3'b101;
				rom_word.flag_ld = 1'b1;
				rom_word.res_wr = 1'b1;
				rom_word.dst_wr = 1'b1;
			end
			`OP_XOR: begin
				rom_word.alu_func = 3'b110;
				rom_word.flag_ld = 1'b1;
				rom_word.res_wr = 1'b1;
				rom_word.dst_wr = 1'b1;
			end
			// Subtract for flags only, result discarded
			`OP_CMP: begin
				rom_word.alu_func = 3'b001;
				rom_word.flag_ld = 1'b1;
			end
			`OP_LOAD: begin
				rom_word.mem_rd = 1'b1;
				rom_word.dst_wr = 1'b1;
			end
			`OP_STORE: rom_word.mem_wr = 1'b1;
			`OP_JUMP: rom_word.jump_abs = 1'b1;
			`OP_JR: rom_word.jump_rel = 1'b1;
			`OP_NOP: rom_word = '0;
			default: rom_word = '0;
		endcase
	end

	// Decode registers, held until the next instruction
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			mword <= '0;
			src_reg <= '0;
			dst_reg <= '0;
		end else if (take.ins) begin
			mword <= rom_word;
			src_reg <= src_fld;
			dst_reg <= dst_fld;
		end
	end

	// Immediate assembly, high word lands above the low word
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			imm_lo <= '0;
			movei_dst <= '0;
			imm_data <= '0;
			imm_dst <= '0;
		end else begin
			if (take.movei)
				movei_dst <= dst_fld;
			if (take.imm_lo)
				imm_lo <= ins_word;
			if (take.imm_hi) begin
				imm_data <= {ins_word, imm_lo};
				imm_dst <= movei_dst;
			end
		end
	end

	// One-cycle pulses for the execute stage
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			exe <= 1'b0;
			imm_wr <= 1'b0;
		end else begin
			exe <= take.ins;
			imm_wr <= take.imm_hi;
		end
	end

	// Register file sees one writer per cycle
	a_exe_imm_excl: assert property (@(posedge sys_clk) disable iff (!resetl)
		!(exe && imm_wr))
		else $error("ins_regs: exe and imm_wr together");

endmodule

`default_nettype wire

// File: exec_ctrl.sv
// Execute control, gates the decoded microword with exe and the jump condition
`default_nettype none

`include "ins_exec_settings.svh"

module exec_ctrl (
	input wire logic exe,
	input wire ins_exec_pkg::microword_t mword,
	input wire ins_exec_pkg::reg_sel_t cond,
	input wire ins_exec_pkg::cpu_flags_t flags,
	output ins_exec_pkg::exec_strobes_t strobes,
	output logic flag_depend
);

	logic other_flag;
	logic need_z_ok;
	logic need_nz_ok;
	logic need_f_ok;
	logic need_nf_ok;
	logic cond_ok;
	logic jump;

	// Second flag is negative or carry, picked by SEL
	assign other_flag = cond[`COND_SEL] ? flags.negative : flags.carry;

	// Each requested flag state must hold
	// Unset bits never block the jump
	assign need_z_ok = ~cond[`COND_Z] | flags.zero;
	assign need_nz_ok = ~cond[`COND_NZ] | ~flags.zero;
	assign need_f_ok = ~cond[`COND_F] | other_flag;
	assign need_nf_ok = ~cond[`COND_NF] | ~other_flag;

	// Empty field means always
	assign cond_ok = need_z_ok & need_nz_ok & need_f_ok & need_nf_ok;

	// Jump of either kind in decode
	assign jump = mword.jump_rel | mword.jump_abs;

	// Strobes live only for the execute cycle
	always_comb begin
		strobes.alu_func = mword.alu_func & {`ALU_W{exe}};
		strobes.flag_ld = exe & mword.flag_ld;
		strobes.res_wr = exe & mword.res_wr;
		strobes.dst_wr = exe & mword.dst_wr;
		strobes.mem_rd = exe & mword.mem_rd;
		strobes.mem_wr = exe & mword.mem_wr;
		// Jumps additionally need the condition
		strobes.jump_rel = exe & mword.jump_rel & cond_ok;
		strobes.jump_abs = exe & mword.jump_abs & cond_ok;
	end

	// Conditional jump, flags must be settled before execute
	assign flag_depend = exe & jump & (|cond);

	// ROM never codes both jump kinds in one entry
	always_comb begin
		a_one_jump: assert (!(strobes.jump_rel && strobes.jump_abs))
			else $error("exec_ctrl: jump_rel and jump_abs together");
	end

endmodule

`default_nettype wire

// File: ins_exec.sv
// Top of the instruction execution front end, connects sequencer, decode and execute control
`default_nettype none

`include "ins_exec_settings.svh"

module ins_exec (
	input wire logic sys_clk,
	input wire logic resetl,
	input wire logic go,
	input wire logic ins_rdy,
	input wire ins_exec_pkg::ins_word_t ins_word,
	input wire ins_exec_pkg::cpu_flags_t flags,
	output logic exe,
	output ins_exec_pkg::exec_strobes_t strobes,
	output logic flag_depend,
	output ins_exec_pkg::reg_sel_t src_reg,
	output ins_exec_pkg::reg_sel_t dst_reg,
	output ins_exec_pkg::imm_t imm_data,
	output logic imm_wr,
	output ins_exec_pkg::reg_sel_t imm_dst
);

	ins_exec_pkg::word_take_t take;
	ins_exec_pkg::microword_t mword;

	// Word classification and MOVEI tracking
	movei_seq u_movei_seq (
		.sys_clk(sys_clk),
		.resetl(resetl),
		.go(go),
		.ins_rdy(ins_rdy),
		.opcode(ins_word[`INS_W-1 -: `OP_W]),
		.take(take)
	);

	// Decode registers and microcode ROM
	ins_regs u_ins_regs (
		.sys_clk(sys_clk),
		.resetl(resetl),
		.take(take),
		.ins_word(ins_word),
		.exe(exe),
		.mword(mword),
		.src_reg(src_reg),
		.dst_reg(dst_reg),
		.imm_data(imm_data),
		.imm_wr(imm_wr),
		.imm_dst(imm_dst)
	);

	// Condition code comes from the latched destination field
	exec_ctrl u_exec_ctrl (
		.exe(exe),
		.mword(mword),
		.cond(dst_reg),
		.flags(flags),
		.strobes(strobes),
		.flag_depend(flag_depend)
	);

endmodule

`default_nettype wire

// File: ins_exec_checker.sv
// Testbench checker, models the front end from the DUT inputs and compares every DUT output
`default_nettype none

`include "ins_exec_settings.svh"

module ins_exec_checker (
	input wire logic sys_clk,
	input wire logic resetl,
	input wire logic go,
	input wire logic ins_rdy,
	input wire ins_exec_pkg::ins_word_t ins_word,
	input wire ins_exec_pkg::cpu_flags_t flags,
	input wire logic exe,
	input wire ins_exec_pkg::exec_strobes_t strobes,
	input wire logic flag_depend,
	input wire ins_exec_pkg::reg_sel_t src_reg,
	input wire ins_exec_pkg::reg_sel_t dst_reg,
	input wire ins_exec_pkg::imm_t imm_data,
	input wire logic imm_wr,
	input wire ins_exec_pkg::reg_sel_t imm_dst
);

	int err_count;
	int check_count;
	int exe_seen;
	int imm_seen;

	// Model of the decode state
	ins_exec_pkg::movei_state_t st;
	ins_exec_pkg::microword_t m_mword;
	ins_exec_pkg::reg_sel_t m_src;
	ins_exec_pkg::reg_sel_t m_dst;
	ins_exec_pkg::reg_sel_t mv_dst;
	ins_exec_pkg::ins_word_t lo_word;
	ins_exec_pkg::imm_t m_imm;
	ins_exec_pkg::reg_sel_t m_immdst;
	logic pend_ins;
	logic pend_imm;
	ins_exec_pkg::exec_strobes_t exp_s;
	logic exp_dep;

	// Reference microcode table
	function automatic ins_exec_pkg::microword_t rom_ref(input ins_exec_pkg::opcode_t op);
		ins_exec_pkg::microword_t m;
		m = '0;
		case (op)
			`OP_ADD: m = '{3'b000, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0};
			`OP_SUB: m = '{3'b001, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0};
			`OP_AND: m = '{3'b100, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0};
			`OP_OR: m = '{3'b101, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0};
			`OP_XOR: m = '{3'b110, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0};
			`OP_CMP: m = '{3'b001, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0};
			`OP_LOAD: m = '{3'b000, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0};
			`OP_STORE: m = '{3'b000, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
			`OP_JUMP: m.jump_abs = 1'b1;
			`OP_JR: m.jump_rel = 1'b1;
			default: m = '0;
		endcase
		return m;
	endfunction

	// Condition rule, every requested flag state must hold
	function automatic logic cond_met(input ins_exec_pkg::reg_sel_t c,
			input ins_exec_pkg::cpu_flags_t f);
		logic other;
		logic ok;
		other = c[`COND_SEL] ? f.negative : f.carry;
		ok = 1'b1;
		if (c[`COND_Z] && !f.zero)
			ok = 1'b0;
		if (c[`COND_NZ] && f.zero)
			ok = 1'b0;
		if (c[`COND_F] && !other)
			ok = 1'b0;
		if (c[`COND_NF] && other)
			ok = 1'b0;
		return ok;
	endfunction

	// Expected strobes for the execute cycle
	function automatic ins_exec_pkg::exec_strobes_t expect_strobes(
			input ins_exec_pkg::microword_t m, input logic e,
			input ins_exec_pkg::reg_sel_t c, input ins_exec_pkg::cpu_flags_t f);
		ins_exec_pkg::exec_strobes_t s;
		s = '0;
		if (e) begin
			s = m;
			s.jump_rel = m.jump_rel & cond_met(c, f);
			s.jump_abs = m.jump_abs & cond_met(c, f);
		end
		return s;
	endfunction

	task automatic check_value(input string what, input logic [31:0] got,
			input logic [31:0] expv);
		check_count++;
		if (got !== expv) begin
			err_count++;
			$display("FAIL at time %0t: %s got %h expected %h", $time, what, got, expv);
		end
	endtask

	initial begin
		err_count = 0;
		check_count = 0;
		exe_seen = 0;
		imm_seen = 0;
	end

	// Track accepted words on the rising edge
	always @(posedge sys_clk) begin
		if (!resetl) begin
			st = ins_exec_pkg::IDLE;
			m_mword = '0;
			m_src = '0;
			m_dst = '0;
			mv_dst = '0;
			lo_word = '0;
			m_imm = '0;
			m_immdst = '0;
			pend_ins = 1'b0;
			pend_imm = 1'b0;
		end else begin
			pend_ins = 1'b0;
			pend_imm = 1'b0;
			if (go && ins_rdy) begin
				case (st)
					ins_exec_pkg::IDLE: begin
						if (ins_word[15:10] == `OP_MOVEI) begin
							mv_dst = ins_word[4:0];
							st = ins_exec_pkg::AWAIT_LO;
						end else begin
							m_mword = rom_ref(ins_word[15:10]);
							m_src = ins_word[9:5];
							m_dst = ins_word[4:0];
							pend_ins = 1'b1;
						end
					end
					ins_exec_pkg::AWAIT_LO: begin
						lo_word = ins_word;
						st = ins_exec_pkg::AWAIT_HI;
					end
					default: begin
						m_imm = {ins_word, lo_word};
						m_immdst = mv_dst;
						pend_imm = 1'b1;
						st = ins_exec_pkg::IDLE;
					end
				endcase
			end
		end
	end

	// Compare mid-cycle, outputs and flags are settled
	always @(negedge sys_clk) begin
		if (resetl) begin
			exp_s = expect_strobes(m_mword, pend_ins, m_dst, flags);
			exp_dep = pend_ins & (m_mword.jump_rel | m_mword.jump_abs) & (|m_dst);
			check_value("exe", 32'(exe), 32'(pend_ins));
			check_value("imm_wr", 32'(imm_wr), 32'(pend_imm));
			check_value("strobes", 32'(strobes), 32'(exp_s));
			check_value("flag_depend", 32'(flag_depend), 32'(exp_dep));
			check_value("src_reg", 32'(src_reg), 32'(m_src));
			check_value("dst_reg", 32'(dst_reg), 32'(m_dst));
			check_value("imm_data", imm_data, m_imm);
			check_value("imm_dst", 32'(imm_dst), 32'(m_immdst));
			if (exe)
				exe_seen++;
			if (imm_wr)
				imm_seen++;
		end
	end

endmodule

`default_nettype wire

// File: ins_exec_tb.sv
// Testbench top that drives seeded instruction streams into the front end and reports the results
`default_nettype none

`include "ins_exec_settings.svh"

module ins_exec_tb;

	logic sys_clk;
	logic resetl;
	logic go;
	logic ins_rdy;
	ins_exec_pkg::ins_word_t ins_word;
	ins_exec_pkg::cpu_flags_t flags;
	logic exe;
	ins_exec_pkg::exec_strobes_t strobes;
	logic flag_depend;
	ins_exec_pkg::reg_sel_t src_reg;
	ins_exec_pkg::reg_sel_t dst_reg;
	ins_exec_pkg::imm_t imm_data;
	logic imm_wr;
	ins_exec_pkg::reg_sel_t imm_dst;

	integer seed;
	logic [31:0] r;
	int exp_exe_n;
	int exp_imm_n;
	int errs_before;
	int test_num;
	logic timed_out;
	ins_exec_pkg::opcode_t ops [11];

	// Period of 40
	always #20 sys_clk = ~sys_clk;

	ins_exec UUT (.*);

	// Watches every DUT port and counts mismatches
	ins_exec_checker u_chk (.*);

	// No strobe, random word and flags on the bus
	task automatic idle_cycle();
		@(posedge sys_clk);
		r = $random(seed);
		ins_rdy <= 1'b0;
		ins_word <= r[15:0];
		flags <= r[18:16];
	endtask

	// One strobed word with go set by run
	task automatic send_word(input ins_exec_pkg::ins_word_t w, input logic run);
		@(posedge sys_clk);
		r = $random(seed);
		go <= run;
		ins_rdy <= 1'b1;
		ins_word <= w;
		flags <= r[18:16];
	endtask

	// Zero to three idle cycles
	task automatic random_gap();
		int n;
		r = $random(seed);
		n = int'(r[1:0]);
		for (int i = 0; i < n; i++)
			idle_cycle();
	endtask

	// Drain until every expected pulse was seen
	task automatic end_test(input string name);
		int t;
		t = 0;
		idle_cycle();
		while ((u_chk.exe_seen != exp_exe_n || u_chk.imm_seen != exp_imm_n) && t < 50) begin
			idle_cycle();
			t++;
		end
		if (u_chk.exe_seen != exp_exe_n || u_chk.imm_seen != exp_imm_n) begin
			$display("Timeout: exe or imm_wr pulse count never matched in %s", name);
			timed_out = 1'b1;
		end
		$display("test %0d %s: %0d errors", test_num, name, u_chk.err_count - errs_before);
		test_num++;
		errs_before = u_chk.err_count;
	endtask

	initial begin
		sys_clk = 1'b0;
		resetl = 1'b0;
		go = 1'b0;
		ins_rdy = 1'b0;
		ins_word = '0;
		flags = '0;
		seed = 74601;
		exp_exe_n = 0;
		exp_imm_n = 0;
		errs_before = 0;
		test_num = 1;
		timed_out = 1'b0;
		ops = '{`OP_ADD, `OP_SUB, `OP_AND, `OP_OR, `OP_XOR, `OP_CMP, `OP_LOAD, `OP_STORE,
			`OP_JUMP, `OP_JR, `OP_NOP};
		repeat (4) @(posedge sys_clk);
		resetl <= 1'b1;
		go <= 1'b1;
		repeat (5) idle_cycle();
		end_test("quiet after reset");
		// Subset opcodes plus some unlisted ones
		for (int i = 0; i < 40; i++) begin
			r = $random(seed);
			exp_exe_n++;
			if (r[3:0] == 4'd0)
				send_word({(r[15:10] == `OP_MOVEI) ? 6'd63 : r[15:10], r[25:16]}, 1'b1);
			else
				send_word({ops[int'(r[7:4]) % 11], r[25:16]}, 1'b1);
			random_gap();
		end
		end_test("random instructions");
		// Random condition fields, flags change every cycle
		for (int i = 0; i < 40; i++) begin
			r = $random(seed);
			exp_exe_n++;
			send_word({r[0] ? `OP_JUMP : `OP_JR, r[15:6]}, 1'b1);
			random_gap();
		end
		end_test("conditional jumps");
		for (int i = 0; i < 8; i++) begin
			r = $random(seed);
			send_word({`OP_MOVEI, r[9:0]}, 1'b1);
			random_gap();
			r = $random(seed);
			send_word(r[31:16], 1'b1);
			random_gap();
			r = $random(seed);
			send_word(r[15:0], 1'b1);
			exp_imm_n++;
			random_gap();
		end
		end_test("movei sequences");
		// Ignored words around and inside a MOVEI
		for (int i = 0; i < 6; i++) begin
			r = $random(seed);
			send_word({ops[int'(r[7:4]) % 11], r[25:16]}, 1'b0);
			r = $random(seed);
			send_word({`OP_MOVEI, r[9:0]}, 1'b1);
			send_word(r[31:16], 1'b0);
			send_word(r[15:0], 1'b1);
			idle_cycle();
			send_word({`OP_ADD, r[9:0]}, 1'b0);
			send_word(r[31:16], 1'b1);
			exp_imm_n++;
			random_gap();
		end
		end_test("go low ignores words");
		$display("checks %0d errors %0d", u_chk.check_count, u_chk.err_count);
		if (!timed_out && u_chk.err_count == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: list.f
+incdir+.
ins_exec_pkg.sv
movei_seq.sv
ins_regs.sv
exec_ctrl.sv
ins_exec.sv
ins_exec_checker.sv
ins_exec_tb.sv

// File: run.sh
#!/bin/sh
# Build the simulation with Verilator and run it, status follows the pass message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f list.f --top-module ins_exec_tb -o ins_exec_sim \
	&& ./obj_dir/ins_exec_sim | tee /dev/stderr | grep -q "all tests passed" \
	&& echo "PASS" \
	|| { echo "FAIL"; exit 1; }

exit 0
